/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_cd_top
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

SOURCES := $(shell cat $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "test passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* cd_csr.sv */
// host register block holding configuration, sticky interrupt flags and command pulses
`default_nettype none

module cd_csr import cdbus_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_n,
    input  csr_req_t        csr_req,
    input  wire logic [7:0] rx_ram_rd_flags,
    input  wire logic       rx_error,
    input  wire logic       rx_ram_lost,
    input  wire logic       rx_break,
    input  wire logic       rx_pending,
    input  wire logic       bus_idle,
    input  wire logic       ack_break,
    input  wire logic       tx_pending,
    input  wire logic       cd,
    input  wire logic       tx_err,
    output logic     [31:0] csr_readdata,
    output cd_cfg_t         cfg,
    output logic            rx_ram_rd_done,
    output logic            rx_clean_all,
    output logic            tx_ram_switch,
    output logic            tx_abort,
    output logic            has_break,
    output logic            irq
);

    logic       tx_error_flag;
    logic       cd_flag;
    logic       rx_error_flag;
    logic       rx_lost_flag;
    logic       rx_break_flag;
    logic [7:0] int_mask;
    logic [7:0] int_flag;
    csr_reg_e   reg_addr;
    logic [3:0] be;
    logic [31:0] wd;

    assign reg_addr = csr_reg_e'(csr_req.address);
    assign be       = csr_req.byteenable;
    assign wd       = csr_req.writedata;

    always_comb begin
        int_flag                 = '0;
        int_flag[INT_BUS_IDLE]   = bus_idle;
        int_flag[INT_RX_PENDING] = rx_pending;
        int_flag[INT_RX_BREAK]   = rx_break_flag;
        int_flag[INT_RX_LOST]    = rx_lost_flag;
        int_flag[INT_RX_ERROR]   = rx_error_flag;
        int_flag[INT_TX_DONE]    = ~tx_pending; // the transmit slot is free again
        int_flag[INT_CD]         = cd_flag;
        int_flag[INT_TX_ERROR]   = tx_error_flag;
    end

    assign irq = |(int_flag & int_mask);

    always_comb begin
        case (reg_addr)
            VERSION:       csr_readdata = {24'd0, CD_VERSION};
            SETTING:       csr_readdata = {25'd0, cfg.full_duplex, cfg.break_sync,
                                           cfg.arbitration, cfg.not_drop, cfg.user_crc,
                                           cfg.tx_invert, cfg.tx_push_pull};
            IDLE_WAIT_LEN: csr_readdata = {24'd0, cfg.idle_wait_len};
            TX_PERMIT_LEN: csr_readdata = {22'd0, cfg.tx_permit_len};
            MAX_IDLE_LEN:  csr_readdata = {22'd0, cfg.max_idle_len};
            TX_PRE_LEN:    csr_readdata = {30'd0, cfg.tx_pre_len};
            FILTER:        csr_readdata = {24'd0, cfg.filter};
            DIV_LS:        csr_readdata = {16'd0, cfg.div_ls};
            DIV_HS:        csr_readdata = {16'd0, cfg.div_hs};
            INT_FLAG:      csr_readdata = {24'd0, int_flag};
            INT_MASK:      csr_readdata = {24'd0, int_mask};
            TX_CTRL:       csr_readdata = {26'd0, has_break, 5'd0}; // break still waiting
            RX_PAGE_FLAG:  csr_readdata = {24'd0, rx_ram_rd_flags};
            FILTER_M:      csr_readdata = {16'd0, cfg.filter2, cfg.filter1};
            default:       csr_readdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cfg <= '{full_duplex: 1'b0, break_sync: 1'b0, arbitration: 1'b1,
                     not_drop: 1'b0, user_crc: 1'b0, tx_invert: 1'b0,
                     tx_push_pull: 1'b0, idle_wait_len: 8'd10, tx_permit_len: 10'd20,
                     max_idle_len: 10'd200, tx_pre_len: 2'd1, filter: 8'hff,
                     filter1: 8'hff, filter2: 8'hff, div_ls: DIV_LS_RST,
                     div_hs: DIV_HS_RST};
            tx_error_flag  <= 1'b0;
            cd_flag        <= 1'b0;
            rx_error_flag  <= 1'b0;
            rx_lost_flag   <= 1'b0;
            rx_break_flag  <= 1'b0;
            int_mask       <= '0;
            rx_ram_rd_done <= 1'b0;
            rx_clean_all   <= 1'b0;
            tx_ram_switch  <= 1'b0;
            tx_abort       <= 1'b0;
            has_break      <= 1'b0;
        end else begin
            rx_ram_rd_done <= 1'b0;
            rx_clean_all   <= 1'b0;
            tx_ram_switch  <= 1'b0;
            tx_abort       <= 1'b0;

            if (rx_error)
                rx_error_flag <= 1'b1;
            if (rx_ram_lost)
                rx_lost_flag <= 1'b1;
            if (rx_break)
                rx_break_flag <= 1'b1;
            if (cd)
                cd_flag <= 1'b1;
            if (tx_err)
                tx_error_flag <= 1'b1;
            if (ack_break)
                has_break <= 1'b0;

            // the host write comes last so a clear bit wins over an event in the same cycle
            if (csr_req.write) begin
                case (reg_addr)
                    SETTING: if (be[0]) begin
                        {cfg.full_duplex, cfg.break_sync, cfg.arbitration, cfg.not_drop,
                         cfg.user_crc, cfg.tx_invert, cfg.tx_push_pull} <= wd[6:0];
                    end
                    IDLE_WAIT_LEN: if (be[0]) cfg.idle_wait_len <= wd[7:0];
                    TX_PERMIT_LEN: begin
                        if (be[0]) cfg.tx_permit_len[7:0] <= wd[7:0];
                        if (be[1]) cfg.tx_permit_len[9:8] <= wd[9:8];
                    end
                    MAX_IDLE_LEN: begin
                        if (be[0]) cfg.max_idle_len[7:0] <= wd[7:0];
                        if (be[1]) cfg.max_idle_len[9:8] <= wd[9:8];
                    end
                    TX_PRE_LEN: if (be[0]) cfg.tx_pre_len <= wd[1:0];
                    FILTER:     if (be[0]) cfg.filter <= wd[7:0];
                    DIV_LS: begin
                        if (be[0]) cfg.div_ls[7:0]  <= wd[7:0];
                        if (be[1]) cfg.div_ls[15:8] <= wd[15:8];
                    end
                    DIV_HS: begin
                        if (be[0]) cfg.div_hs[7:0]  <= wd[7:0];
                        if (be[1]) cfg.div_hs[15:8] <= wd[15:8];
                    end
                    INT_MASK: if (be[0]) int_mask <= wd[7:0];
                    RX_CTRL: if (be[0]) begin
                        if (wd[1]) rx_ram_rd_done <= 1'b1;
                        if (wd[2]) rx_lost_flag   <= 1'b0;
                        if (wd[3]) rx_error_flag  <= 1'b0;
                        if (wd[4]) rx_clean_all   <= 1'b1;
                        if (wd[5]) rx_break_flag  <= 1'b0;
                    end
                    TX_CTRL: if (be[0]) begin
                        if (wd[1]) tx_ram_switch <= 1'b1;
                        if (wd[2]) cd_flag       <= 1'b0;
                        if (wd[3]) tx_error_flag <= 1'b0;
                        if (wd[4]) tx_abort      <= 1'b1;
                        if (wd[5]) has_break     <= 1'b1;
                    end
                    FILTER_M: begin
                        if (be[0]) cfg.filter1 <= wd[7:0];
                        if (be[1]) cfg.filter2 <= wd[15:8];
                    end
                    default: ;
                endcase
            end
        end
    end

    // a break is only acknowledged while it is requested, so a new request never meets an ack
    a_break_handshake: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(has_break) |-> !$past(ack_break));

endmodule

`default_nettype wire

/* cd_idle_timer.sv */
// bus line monitor that measures idle and low time in bit periods for idle, permit and break
`default_nettype none

module cd_idle_timer import cdbus_pkg::*; (
    input  wire logic clk,
    input  wire logic reset_n,
    input  cd_cfg_t   cfg,
    input  wire logic bus_rx,
    output logic      bus_idle,
    output logic      tx_permit,
    output logic      rx_break
);

    logic [1:0]  rx_sync;
    logic [15:0] div_cnt;
    logic        bit_tick;
    logic [9:0]  high_cnt;
    logic [9:0]  low_cnt;
    logic        line;

    assign line     = rx_sync[1];
    assign bit_tick = (div_cnt == cfg.div_ls);

    assign bus_idle  = (high_cnt >= {2'b00, cfg.idle_wait_len});
    assign tx_permit = (high_cnt >= cfg.tx_permit_len);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rx_sync  <= 2'b11; // the line rests high
            div_cnt  <= '0;
            high_cnt <= '0;
            low_cnt  <= '0;
            rx_break <= 1'b0;
        end else begin
            rx_sync  <= {rx_sync[0], bus_rx};
            div_cnt  <= bit_tick ? 16'd0 : div_cnt + 16'd1;
            rx_break <= 1'b0;

            if (!line)
                high_cnt <= '0;
            else if (bit_tick && high_cnt != 10'h3ff)
                high_cnt <= high_cnt + 10'd1;

            if (line) begin
                low_cnt <= '0;
            end else if (bit_tick && low_cnt != 10'h3ff) begin
                low_cnt <= low_cnt + 10'd1;
                if ({1'b0, low_cnt} + 11'd1 == {1'b0, cfg.max_idle_len})
                    rx_break <= 1'b1; // once per low run, the count only passes this value once
            end
        end
    end

    a_break_single: assert property (@(posedge clk) disable iff (!reset_n)
        rx_break |=> !rx_break);

endmodule

`default_nettype wire

/* cd_rx_pages.sv */
// two-page receive bookkeeper that filters frame descriptors and tracks page occupancy
`default_nettype none

module cd_rx_pages import cdbus_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_n,
    input  cd_cfg_t         cfg,
    input  rx_frame_t       rx_frame,
    input  wire logic       rx_ram_rd_done,
    input  wire logic       rx_clean_all,
    output logic            rx_pending,
    output logic      [7:0] rx_ram_rd_flags,
    output logic            rx_error,
    output logic            rx_ram_lost
);

    logic [1:0]      page_full;
    logic [1:0][7:0] page_flags;
    logic            wr_idx;
    logic            rd_idx;
    logic            addr_hit;
    logic            accept;
    logic            keep;
    logic            store;

    assign addr_hit = (rx_frame.dst == cfg.filter) || (rx_frame.dst == cfg.filter1) ||
                      (rx_frame.dst == cfg.filter2) || (rx_frame.dst == BROADCAST_ADDR);
    assign accept   = rx_frame.valid && addr_hit;
    assign keep     = accept && (rx_frame.crc_ok || cfg.not_drop);
    assign store    = keep && !(&page_full);

    assign rx_pending      = page_full[rd_idx];
    assign rx_ram_rd_flags = page_flags[rd_idx];

    always_ff @(posedge clk) begin
        if (store)
            page_flags[wr_idx] <= rx_frame.flags;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            page_full   <= '0;
            wr_idx      <= 1'b0;
            rd_idx      <= 1'b0;
            rx_error    <= 1'b0;
            rx_ram_lost <= 1'b0;
        end else begin
            rx_error    <= accept && !rx_frame.crc_ok;
            rx_ram_lost <= keep && (&page_full);

            if (store) begin
                page_full[wr_idx] <= 1'b1;
                wr_idx            <= ~wr_idx;
            end
            if (rx_ram_rd_done && page_full[rd_idx]) begin
                page_full[rd_idx] <= 1'b0;
                rd_idx            <= ~rd_idx;
            end
            if (rx_clean_all) begin
                page_full <= '0;
                wr_idx    <= 1'b0;
                rd_idx    <= 1'b0;
            end
        end
    end

    // both pages full means the write index has come round to an occupied read page
    a_lost_when_full: assert property (@(posedge clk) disable iff (!reset_n)
        rx_ram_lost |-> $past(rx_pending && (wr_idx == rd_idx)));

endmodule

`default_nettype wire

/* cd_top.sv */
// top level of the bus controller status side, joining host port, bus side and the four blocks
`default_nettype none

module cd_top import cdbus_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset_n,
    input  csr_req_t    csr_req,
    input  wire logic   bus_rx,
    input  rx_frame_t   rx_frame,
    input  tx_result_t  tx_result,
    output logic [31:0] csr_readdata,
    output logic        irq,
    output logic        tx_start,
    output logic        tx_break
);

    cd_cfg_t    cfg;
    logic       rx_ram_rd_done;
    logic       rx_clean_all;
    logic       tx_ram_switch;
    logic       tx_abort;
    logic       has_break;
    logic       ack_break;
    logic [7:0] rx_ram_rd_flags;
    logic       rx_error;
    logic       rx_ram_lost;
    logic       rx_break;
    logic       rx_pending;
    logic       bus_idle;
    logic       tx_permit;
    logic       tx_pending;
    logic       cd;
    logic       tx_err;

    cd_csr u_csr (
        .clk, .reset_n, .csr_req, .rx_ram_rd_flags, .rx_error, .rx_ram_lost, .rx_break,
        .rx_pending, .bus_idle, .ack_break, .tx_pending, .cd, .tx_err, .csr_readdata,
        .cfg, .rx_ram_rd_done, .rx_clean_all, .tx_ram_switch, .tx_abort, .has_break, .irq
    );

    cd_idle_timer u_idle_timer (
        .clk, .reset_n, .cfg, .bus_rx, .bus_idle, .tx_permit, .rx_break
    );

    cd_rx_pages u_rx_pages (
        .clk, .reset_n, .cfg, .rx_frame, .rx_ram_rd_done, .rx_clean_all, .rx_pending,
        .rx_ram_rd_flags, .rx_error, .rx_ram_lost
    );

    cd_tx_ctrl u_tx_ctrl (
        .clk, .reset_n, .cfg, .tx_ram_switch, .tx_abort, .has_break, .tx_permit, .bus_idle,
        .tx_result, .tx_pending, .tx_start, .tx_break, .ack_break, .cd, .tx_err
    );

endmodule

`default_nettype wire

/* cd_tx_ctrl.sv */
// transmit controller for one pending frame with start, result handling, abort and break
`default_nettype none

module cd_tx_ctrl import cdbus_pkg::*; (
    input  wire logic clk,
    input  wire logic reset_n,
    input  cd_cfg_t   cfg,
    input  wire logic tx_ram_switch,
    input  wire logic tx_abort,
    input  wire logic has_break,
    input  wire logic tx_permit,
    input  wire logic bus_idle,
    input  tx_result_t tx_result,
    output logic      tx_pending,
    output logic      tx_start,
    output logic      tx_break,
    output logic      ack_break,
    output logic      cd,
    output logic      tx_err
);

    typedef enum logic {
        IDLE,
        BUSY
    } tx_state_e;

    tx_state_e state;
    logic      pending;
    logic      settle;

    assign tx_pending = pending;

    // a break goes out only between frames and takes priority over a start
    assign tx_break  = (state == IDLE) && has_break && bus_idle;
    assign ack_break = tx_break;
    assign tx_start  = (state == IDLE) && pending && tx_permit && !tx_break && !tx_abort;
    assign settle    = (state == BUSY) && tx_result.valid;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= IDLE;
            pending <= 1'b0;
            cd      <= 1'b0;
            tx_err  <= 1'b0;
        end else begin
            cd     <= 1'b0;
            tx_err <= 1'b0;

            if (tx_ram_switch)
                pending <= 1'b1;
            if (tx_start)
                state <= BUSY;

            if (settle) begin
                state <= IDLE;
                case (tx_result.kind)
                    TX_OK: pending <= 1'b0;
                    TX_COLLISION: begin
                        cd      <= 1'b1;
                        pending <= cfg.arbitration; // retry only under arbitration
                    end
                    default: begin
                        tx_err  <= 1'b1;
                        pending <= 1'b0;
                    end
                endcase
            end

            if (tx_abort) begin
                state   <= IDLE;
                pending <= 1'b0;
            end
        end
    end

    // a line result only follows a frame that was started
    a_result_when_busy: assert property (@(posedge clk) disable iff (!reset_n)
        tx_result.valid |-> (state == BUSY));

endmodule

`default_nettype wire

/* cdbus_pkg.sv */
// shared register map, reset values and bus types, imported by every design file and the testbench
`default_nettype none

package cdbus_pkg;

    localparam logic [7:0]  CD_VERSION     = 8'd11;
    localparam logic [15:0] DIV_LS_RST     = 16'd346; // 115200 bps from a 40 MHz clock
    localparam logic [15:0] DIV_HS_RST     = 16'd346;
    localparam logic [7:0]  BROADCAST_ADDR = 8'hff;

    // bit positions inside the interrupt flag and mask bytes
    localparam int INT_BUS_IDLE   = 0;
    localparam int INT_RX_PENDING = 1;
    localparam int INT_RX_BREAK   = 2;
    localparam int INT_RX_LOST    = 3;
    localparam int INT_RX_ERROR   = 4;
    localparam int INT_TX_DONE    = 5;
    localparam int INT_CD         = 6;
    localparam int INT_TX_ERROR   = 7;

    typedef enum logic [3:0] {
        VERSION, SETTING, IDLE_WAIT_LEN, TX_PERMIT_LEN, MAX_IDLE_LEN, TX_PRE_LEN,
        FILTER, DIV_LS, DIV_HS, INT_FLAG, INT_MASK, RX_CTRL, TX_CTRL, RX_PAGE_FLAG,
        FILTER_M
    } csr_reg_e;

    typedef struct packed {
        logic [3:0]  address;
        logic [3:0]  byteenable;
        logic        read;
        logic        write;
        logic [31:0] writedata;
    } csr_req_t;

    typedef struct packed {
        logic        full_duplex;
        logic        break_sync;
        logic        arbitration;
        logic        not_drop;
        logic        user_crc;
        logic        tx_invert;
        logic        tx_push_pull;
        logic [7:0]  idle_wait_len;
        logic [9:0]  tx_permit_len;
        logic [9:0]  max_idle_len;
        logic [1:0]  tx_pre_len;
        logic [7:0]  filter;
        logic [7:0]  filter1;
        logic [7:0]  filter2;
        logic [15:0] div_ls;
        logic [15:0] div_hs;
    } cd_cfg_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] dst;
        logic [7:0] flags;
        logic       crc_ok;
    } rx_frame_t;

    typedef enum logic [1:0] {
        TX_OK, TX_COLLISION, TX_ERROR
    } tx_result_e;

    typedef struct packed {
        logic       valid;
        tx_result_e kind;
    } tx_result_t;

endpackage

`default_nettype wire

/* filelist.f */
cdbus_pkg.sv
cd_csr.sv
cd_idle_timer.sv
cd_rx_pages.sv
cd_tx_ctrl.sv
cd_top.sv
tb_cd_top.sv

/* tb_cd_top.sv */
// directed testbench for the bus controller status side, built from filelist.f and run by the Makefile
`default_nettype none

module tb_cd_top import cdbus_pkg::*; ();

    logic        clk;
    logic        reset_n;
    csr_req_t    csr_req;
    logic        bus_rx;
    rx_frame_t   rx_frame;
    tx_result_t  tx_result;
    logic [31:0] csr_readdata;
    logic        irq;
    logic        tx_start;
    logic        tx_break;

    integer seed;
    int     errors;
    int     mark;
    int     tests_run;
    int     tests_failed;

    cd_top u_dut (
        .clk, .reset_n, .csr_req, .bus_rx, .rx_frame, .tx_result, .csr_readdata, .irq,
        .tx_start, .tx_break
    );

    always #50 clk = ~clk;

    task automatic check_data(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail time=%0t %s got=0x%0h expected=0x%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail time=%0t %s got=%b expected=%b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flags(input logic [7:0] got, input logic [7:0] exp,
                               input logic [7:0] care);
        if ((got & care) !== (exp & care)) begin
            $display("Fail time=%0t int_flag got=0x%02h expected=0x%02h on bits 0x%02h",
                     $time, got, exp, care);
            errors++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset_n <= 1'b0;
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
    endtask

    task automatic csr_write(input csr_reg_e addr, input logic [3:0] be,
                             input logic [31:0] data);
        csr_req_t req;
        req            = '0;
        req.address    = addr;
        req.byteenable = be;
        req.write      = 1'b1;
        req.writedata  = data;
        @(posedge clk);
        csr_req <= req;
        @(posedge clk);
        csr_req <= '0;
    endtask

    task automatic csr_read(input csr_reg_e addr, output logic [31:0] data);
        csr_req_t req;
        req         = '0;
        req.address = addr;
        req.read    = 1'b1;
        @(posedge clk);
        csr_req <= req;
        @(negedge clk);
        data = csr_readdata; // read data is combinational from the address
    endtask

    task automatic push_frame(input logic [7:0] dst, input logic [7:0] flags,
                              input logic crc_ok);
        rx_frame_t f;
        f.valid  = 1'b1;
        f.dst    = dst;
        f.flags  = flags;
        f.crc_ok = crc_ok;
        @(posedge clk);
        rx_frame <= f;
        @(posedge clk);
        rx_frame <= '0;
    endtask

    task automatic report_result(input tx_result_e kind);
        tx_result_t r;
        r.valid = 1'b1;
        r.kind  = kind;
        @(posedge clk);
        tx_result <= r;
        @(posedge clk);
        tx_result <= '0;
    endtask

    task automatic poll_flag(input int pos, input logic value, input int limit,
                             input string what);
        logic [31:0] d;
        int          n;
        n = 0;
        csr_read(INT_FLAG, d);
        while (d[pos] !== value && n < limit) begin
            csr_read(INT_FLAG, d);
            n++;
        end
        if (d[pos] !== value) begin
            $display("timeout after %0d cycles waiting for %s", limit, what);
            errors++;
        end
    endtask

    task automatic await_strobe(input logic want_break, input int limit, input string what);
        int   n;
        logic seen;
        n = 0;
        @(negedge clk);
        seen = want_break ? tx_break : tx_start;
        while (!seen && n < limit) begin
            @(negedge clk);
            seen = want_break ? tx_break : tx_start;
            n++;
        end
        if (!seen) begin
            $display("timeout after %0d cycles waiting for %s", limit, what);
            errors++;
        end
    endtask

    task automatic hold_without_start(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (tx_start) begin
                $display("tx_start pulsed at time %0t although no frame was pending", $time);
                errors++;
            end
        end
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (errors == mark) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - mark);
        end
        mark = errors;
    endtask

    task automatic reset_values();
        csr_reg_e    regs [10];
        logic [31:0] vals [10];
        logic [31:0] d;
        int          i;
        regs = '{VERSION, SETTING, IDLE_WAIT_LEN, TX_PERMIT_LEN, MAX_IDLE_LEN, TX_PRE_LEN,
                 FILTER, FILTER_M, DIV_LS, DIV_HS};
        vals = '{32'd11, 32'h10, 32'd10, 32'd20, 32'd200, 32'd1,
                 32'hff, 32'hffff, 32'd346, 32'd346};
        for (i = 0; i < 10; i++) begin
            csr_read(regs[i], d);
            check_data("csr_readdata", d, vals[i]);
        end
        csr_read(INT_FLAG, d);
        check_flags(d[7:0], 8'h20, 8'hfe); // only the free transmit slot shows
        check_bit("irq", irq, 1'b0);
    endtask

    task automatic byte_enable_writes();
        csr_reg_e    regs [4];
        string       names [4];
        logic [31:0] widths [4];
        logic [31:0] resets [4];
        logic [31:0] old;
        logic [31:0] wd;
        logic [31:0] expected;
        logic [31:0] got;
        logic [3:0]  be;
        int          r;
        int          i;
        int          b;
        regs   = '{TX_PERMIT_LEN, MAX_IDLE_LEN, DIV_LS, DIV_HS};
        names  = '{"tx_permit_len", "max_idle_len", "div_ls", "div_hs"};
        widths = '{32'h3ff, 32'h3ff, 32'hffff, 32'hffff};
        resets = '{32'd20, 32'd200, 32'd346, 32'd346};
        for (r = 0; r < 4; r++) begin
            old = resets[r];
            for (i = 0; i < 16; i++) begin
                be       = i[3:0];
                wd       = $random(seed);
                expected = old;
                for (b = 0; b < 4; b++)
                    if (be[b])
                        expected[8*b +: 8] = wd[8*b +: 8];
                expected = expected & widths[r]; // bits above the register width read zero
                csr_write(regs[r], be, wd);
                csr_read(regs[r], got);
                check_data(names[r], got, expected);
                old = expected;
            end
        end
    endtask

    task automatic receive_bookkeeping();
        logic [31:0] d;
        csr_write(FILTER, 4'b0001, 32'd5);
        push_frame(8'd5, 8'ha1, 1'b1);
        push_frame(8'd9, 8'hb2, 1'b1); // no filter matches
        push_frame(8'hff, 8'hc3, 1'b1);
        csr_read(INT_FLAG, d);
        check_flags(d[7:0], 8'h02, 8'h1a);
        csr_read(RX_PAGE_FLAG, d);
        check_data("rx_page_flag", d, 32'ha1);
        push_frame(8'd5, 8'hd4, 1'b1); // both pages are taken
        csr_read(INT_FLAG, d);
        check_flags(d[7:0], 8'h0a, 8'h1a);
        push_frame(8'd5, 8'he5, 1'b0);
        csr_read(INT_FLAG, d);
        check_flags(d[7:0], 8'h1a, 8'h1a);
        csr_write(RX_CTRL, 4'b0001, 32'h0c);
        csr_read(INT_FLAG, d);
        check_flags(d[7:0], 8'h02, 8'h1a);
        csr_write(RX_CTRL, 4'b0001, 32'h02);
        csr_read(RX_PAGE_FLAG, d);
        check_data("rx_page_flag", d, 32'hc3);
        csr_read(INT_FLAG, d);
        check_flags(d[7:0], 8'h02, 8'h1a);
        csr_write(RX_CTRL, 4'b0001, 32'h10);
        csr_read(INT_FLAG, d);
        check_flags(d[7:0], 8'h00, 8'h1a);
    endtask

    task automatic idle_timer_irq();
        logic [31:0] d;
        // the bit divider only restarts from reset, so the timer starts from a clean count
        apply_reset();
        csr_write(DIV_LS, 4'b0011, 32'd3);
        csr_write(MAX_IDLE_LEN, 4'b0011, 32'd4);
        poll_flag(INT_BUS_IDLE, 1'b1, 200, "bus idle on a high line");
        @(negedge clk);
        check_bit("irq", irq, 1'b0);
        csr_write(INT_MASK, 4'b0001, 32'h01);
        @(negedge clk);
        check_bit("irq", irq, 1'b1);
        @(posedge clk);
        bus_rx <= 1'b0;
        poll_flag(INT_RX_BREAK, 1'b1, 100, "break detection on a low line");
        csr_read(INT_FLAG, d);
        check_flags(d[7:0], 8'h04, 8'h05);
        check_bit("irq", irq, 1'b0);
        @(posedge clk);
        bus_rx <= 1'b1;
        csr_write(RX_CTRL, 4'b0001, 32'h20);
        poll_flag(INT_BUS_IDLE, 1'b1, 200, "bus idle after the break");
    endtask

    task automatic transmit_control();
        logic [31:0] d;
        csr_write(TX_CTRL, 4'b0001, 32'h02);
        csr_read(INT_FLAG, d);
        check_flags(d[7:0], 8'h00, 8'h20); // frame now pending
        await_strobe(1'b0, 300, "tx_start of the first frame");
        report_result(TX_OK);
        csr_read(INT_FLAG, d);
        check_flags(d[7:0], 8'h20, 8'he0);
        check_bit("tx_start", tx_start, 1'b0);
        csr_write(TX_CTRL, 4'b0001, 32'h02);
        await_strobe(1'b0, 100, "tx_start of the second frame");
        report_result(TX_COLLISION);
        await_strobe(1'b0, 20, "tx_start retry after a collision");
        report_result(TX_ERROR);
        csr_read(INT_FLAG, d);
        check_flags(d[7:0], 8'he0, 8'he0);
        csr_write(TX_CTRL, 4'b0001, 32'h0c);
        csr_read(INT_FLAG, d);
        check_flags(d[7:0], 8'h20, 8'he0);
        @(posedge clk);
        bus_rx <= 1'b0; // a busy line keeps the frame waiting
        poll_flag(INT_BUS_IDLE, 1'b0, 20, "bus idle to drop on a low line");
        csr_write(TX_CTRL, 4'b0001, 32'h02);
        csr_read(INT_FLAG, d);
        check_flags(d[7:0], 8'h00, 8'h20);
        csr_write(TX_CTRL, 4'b0001, 32'h10);
        csr_read(INT_FLAG, d);
        check_flags(d[7:0], 8'h20, 8'h20);
        @(posedge clk);
        bus_rx <= 1'b1;
        hold_without_start(150);
        csr_write(TX_CTRL, 4'b0001, 32'h20);
        await_strobe(1'b1, 20, "tx_break on an idle bus");
        csr_read(TX_CTRL, d);
        check_data("tx_ctrl", d, 32'h00);
        @(posedge clk);
        bus_rx <= 1'b0;
        poll_flag(INT_BUS_IDLE, 1'b0, 20, "bus idle to drop before the second break");
        csr_write(TX_CTRL, 4'b0001, 32'h20);
        csr_read(TX_CTRL, d);
        check_data("tx_ctrl", d, 32'h20);
        check_bit("tx_break", tx_break, 1'b0);
        @(posedge clk);
        bus_rx <= 1'b1;
        await_strobe(1'b1, 200, "tx_break once the bus is idle again");
        csr_read(TX_CTRL, d);
        check_data("tx_ctrl", d, 32'h00);
    endtask

    initial begin
        clk          = 1'b0;
        reset_n      = 1'b0;
        csr_req      = '0;
        bus_rx       = 1'b1;
        rx_frame     = '0;
        tx_result    = '0;
        seed         = 25;
        errors       = 0;
        mark         = 0;
        tests_run    = 0;
        tests_failed = 0;
        apply_reset();
        reset_values();
        close_test("reset values");
        byte_enable_writes();
        close_test("byte enables");
        receive_bookkeeping();
        close_test("receive pages");
        idle_timer_irq();
        close_test("idle timer");
        transmit_control();
        close_test("transmit");
        $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire
